// ==== burger_pkg.sv ====
//==========================================================
// burger package
// shared coordinate types, bus structs, stage map constants,
// key codes and register addresses for the chef core
//==========================================================
`default_nettype none

package burger_pkg;

	typedef logic [9:0] coord_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} chef_pos_t;

	typedef struct packed {
		logic walk;
		logic climb;
	} map_flags_t;

	// hs and vs active low, blank low in the blanking interval
	typedef struct packed {
		logic hs;
		logic vs;
		logic blank;
	} vga_sync_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [3:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	//==========================================================
	// stage geometry
	//==========================================================
	localparam coord_t FLOOR_BASE    = 10'd72;
	localparam coord_t FLOOR_PITCH   = 10'd80;
	localparam coord_t CHEF_Y_MIN    = 10'd72;
	localparam coord_t CHEF_Y_MAX    = 10'd392;
	localparam coord_t LADDER_PITCH  = 10'd96;
	localparam coord_t LADDER_OFFSET = 10'd32;
	localparam coord_t LADDER_WIDTH  = 10'd16;
	localparam coord_t CHEF_HALF     = 10'd8;
	localparam coord_t CHEF_X_MAX    = 10'd624;
	localparam coord_t CHEF_X_START  = 10'd24;
	localparam coord_t CHEF_Y_START  = 10'd392;

	// usb keyboard usage codes, wasd
	localparam logic [7:0] KEY_LEFT  = 8'h04;
	localparam logic [7:0] KEY_RIGHT = 8'h07;
	localparam logic [7:0] KEY_UP    = 8'h1A;
	localparam logic [7:0] KEY_DOWN  = 8'h16;

	localparam logic [3:0] REG_KEYCODE = 4'd0;
	localparam logic [3:0] REG_HEX     = 4'd4;
	localparam logic [3:0] REG_POS     = 4'd8;
	localparam logic [3:0] REG_STATUS  = 4'd12;

endpackage

`default_nettype wire

// ==== vga_sync_gen.sv ====
//==========================================================
// vga sync generator
// pixel enable at half the clock, h and v counters, sync and
// blank outputs, and one frame tick after each vs fall
//==========================================================
`timescale 1ns/100ps
`default_nettype none

module vga_sync_gen #(
	parameter int H_VISIBLE = 640,
	parameter int H_FRONT   = 16,
	parameter int H_SYNC    = 96,
	parameter int H_BACK    = 48,
	parameter int V_VISIBLE = 480,
	parameter int V_FRONT   = 10,
	parameter int V_SYNC    = 2,
	parameter int V_BACK    = 33
) (
	input  wire logic              clk,
	input  wire logic              rst_n,
	output burger_pkg::vga_sync_t  vga,
	output logic                   frame_tick
);

	localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
	localparam int HW      = $clog2(H_TOTAL);
	localparam int VW      = $clog2(V_TOTAL);

	localparam logic [HW-1:0] H_LAST     = HW'(H_TOTAL - 1);
	localparam logic [VW-1:0] V_LAST     = VW'(V_TOTAL - 1);
	localparam logic [HW-1:0] H_SYNC_ON  = HW'(H_VISIBLE + H_FRONT);
	localparam logic [HW-1:0] H_SYNC_OFF = HW'(H_VISIBLE + H_FRONT + H_SYNC);
	localparam logic [VW-1:0] V_SYNC_ON  = VW'(V_VISIBLE + V_FRONT);
	localparam logic [VW-1:0] V_SYNC_OFF = VW'(V_VISIBLE + V_FRONT + V_SYNC);
	localparam logic [HW-1:0] H_VIS_END  = HW'(H_VISIBLE);
	localparam logic [VW-1:0] V_VIS_END  = VW'(V_VISIBLE);

	logic          pix_en;
	logic [HW-1:0] h_cnt;
	logic [VW-1:0] v_cnt;
	logic          vs_d;

	// one pixel every other clock
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix_en <= 1'b0;
			h_cnt  <= '0;
			v_cnt  <= '0;
		end else begin
			pix_en <= ~pix_en;
			if (pix_en) begin
				if (h_cnt == H_LAST) begin
					h_cnt <= '0;
					if (v_cnt == V_LAST)
						v_cnt <= '0;
					else
						v_cnt <= v_cnt + 1'b1;
				end else begin
					h_cnt <= h_cnt + 1'b1;
				end
			end
		end
	end

	// registered sync, blank and the vs falling edge tick
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vga.hs     <= 1'b1;
			vga.vs     <= 1'b1;
			vga.blank  <= 1'b1;
			vs_d       <= 1'b1;
			frame_tick <= 1'b0;
		end else begin
			vga.hs     <= !((h_cnt >= H_SYNC_ON) && (h_cnt < H_SYNC_OFF));
			vga.vs     <= !((v_cnt >= V_SYNC_ON) && (v_cnt < V_SYNC_OFF));
			vga.blank  <= (h_cnt < H_VIS_END) && (v_cnt < V_VIS_END);
			vs_d       <= vga.vs;
			frame_tick <= vs_d & ~vga.vs;
		end
	end

	// the tick lands on the first line of vertical sync
	a_tick_in_vsync: assert property (@(posedge clk) disable iff (!rst_n)
		frame_tick |-> !vga.vs && (v_cnt == V_SYNC_ON));

endmodule

`default_nettype wire

// ==== stage_map.sv ====
//==========================================================
// stage map
// arithmetic floor and ladder rule, gives walk and climb
// permission for the current chef position
//==========================================================
`timescale 1ns/100ps
`default_nettype none

module stage_map (
	input  wire burger_pkg::chef_pos_t  pos,
	output burger_pkg::map_flags_t      flags
);

	import burger_pkg::*;

	logic [9:0]  row_off;
	logic [10:0] probe_x;
	logic [6:0]  lad_phase;
	logic        on_floor_row;
	logic        on_ladder_col;
	logic        in_y_range;

	always_comb begin
		// floors repeat every FLOOR_PITCH rows from FLOOR_BASE
		row_off      = pos.y - FLOOR_BASE;
		on_floor_row = (pos.y >= FLOOR_BASE) && ((row_off % FLOOR_PITCH) == 10'd0);

		// probe at the horizontal centre of the chef sprite
		probe_x   = {1'b0, pos.x} + {1'b0, CHEF_HALF};
		lad_phase = 7'(probe_x % {1'b0, LADDER_PITCH});

		on_ladder_col = (lad_phase >= 7'(LADDER_OFFSET)) &&
			(lad_phase <= 7'(LADDER_OFFSET + LADDER_WIDTH - 10'd1));
		in_y_range    = (pos.y >= CHEF_Y_MIN) && (pos.y <= CHEF_Y_MAX);

		flags.walk  = on_floor_row;
		flags.climb = on_ladder_col && in_y_range;
	end

endmodule

`default_nettype wire

// ==== chef_motion.sv ====
//==========================================================
// chef motion
// steps the chef one pixel per frame tick from the keycode,
// gated by the walk and climb flags and the stage bounds
//==========================================================
`timescale 1ns/100ps
`default_nettype none

module chef_motion (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire logic                    frame_tick,
	input  wire logic [7:0]              keycode,
	input  wire burger_pkg::map_flags_t  flags,
	output burger_pkg::chef_pos_t        pos
);

	import burger_pkg::*;

	chef_pos_t pos_next;
	logic      go_left;
	logic      go_right;
	logic      go_up;
	logic      go_down;

	//==========================================================
	// move decision
	//==========================================================
	always_comb begin
		go_left  = (keycode == KEY_LEFT) && flags.walk && (pos.x > 10'd0);
		go_right = (keycode == KEY_RIGHT) && flags.walk && (pos.x < CHEF_X_MAX);
		go_up    = (keycode == KEY_UP) && flags.climb && (pos.y > CHEF_Y_MIN);
		go_down  = (keycode == KEY_DOWN) && flags.climb && (pos.y < CHEF_Y_MAX);

		pos_next = pos;
		// blocked moves and unknown keys hold
		if (go_left)
			pos_next.x = pos.x - 10'd1;
		else if (go_right)
			pos_next.x = pos.x + 10'd1;
		else if (go_up)
			pos_next.y = pos.y - 10'd1;
		else if (go_down)
			pos_next.y = pos.y + 10'd1;
	end

	//==========================================================
	// position register
	//==========================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos.x <= CHEF_X_START;
			pos.y <= CHEF_Y_START;
		end else if (frame_tick) begin
			pos <= pos_next;
		end
	end

	// vertical range holds across all frames
	a_y_bounds: assert property (@(posedge clk) disable iff (!rst_n)
		(pos.y >= CHEF_Y_MIN) && (pos.y <= CHEF_Y_MAX));

endmodule

`default_nettype wire

// ==== hex_digit_drivers.sv ====
//==========================================================
// seven segment drivers
// four active low hex digits, decimal points off,
// HEX2 and HEX5 held blank
//==========================================================
`timescale 1ns/100ps
`default_nettype none

module hex_digit_drivers (
	input  wire logic [15:0] hex_value,
	output logic [7:0]       hex0,
	output logic [7:0]       hex1,
	output logic [7:0]       hex2,
	output logic [7:0]       hex3,
	output logic [7:0]       hex4,
	output logic [7:0]       hex5
);

	// segments gfedcba, low lights the segment
	function automatic logic [6:0] seg7(input logic [3:0] digit);
		case (digit)
			4'h0: seg7 = 7'b1000000;
			4'h1: seg7 = 7'b1111001;
			4'h2: seg7 = 7'b0100100;
			4'h3: seg7 = 7'b0110000;
			4'h4: seg7 = 7'b0011001;
			4'h5: seg7 = 7'b0010010;
			4'h6: seg7 = 7'b0000010;
			4'h7: seg7 = 7'b1111000;
			4'h8: seg7 = 7'b0000000;
			4'h9: seg7 = 7'b0010000;
			4'hA: seg7 = 7'b0001000;
			4'hB: seg7 = 7'b0000011;
			4'hC: seg7 = 7'b1000110;
			4'hD: seg7 = 7'b0100001;
			4'hE: seg7 = 7'b0000110;
			default: seg7 = 7'b0001110;
		endcase
	endfunction

	assign hex0 = {1'b1, seg7(hex_value[3:0])};
	assign hex1 = {1'b1, seg7(hex_value[7:4])};
	assign hex3 = {1'b1, seg7(hex_value[11:8])};
	assign hex4 = {1'b1, seg7(hex_value[15:12])};

	// no sign or hundreds digit in this core
	assign hex2 = 8'hFF;
	assign hex5 = 8'hFF;

endmodule

`default_nettype wire

// ==== apb_regs.sv ====
//==========================================================
// apb register block
// keycode and hex digit registers, read-only chef position
// and map status, led mirror of keycode and flags
//==========================================================
`timescale 1ns/100ps
`default_nettype none

module apb_regs (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire burger_pkg::apb_req_t    apb,
	output burger_pkg::apb_rsp_t         apb_rsp,
	input  wire burger_pkg::chef_pos_t   pos,
	input  wire burger_pkg::map_flags_t  flags,
	output logic [7:0]                   keycode,
	output logic [15:0]                  hex_value,
	output logic [9:0]                   ledr
);

	import burger_pkg::*;

	logic        access;
	logic        addr_ok;
	logic        wr_en;
	logic [31:0] rd_data;

	//==========================================================
	// address decode
	//==========================================================
	assign access = apb.psel & apb.penable;

	always_comb begin
		case (apb.paddr)
			REG_KEYCODE, REG_HEX, REG_POS, REG_STATUS: addr_ok = 1'b1;
			default: addr_ok = 1'b0;
		endcase
	end

	// pos and status writes fall through silently
	assign wr_en = access & apb.pwrite & addr_ok;

	//==========================================================
	// writable registers
	//==========================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			keycode   <= 8'h00;
			hex_value <= 16'h0000;
		end else if (wr_en) begin
			case (apb.paddr)
				REG_KEYCODE: keycode <= apb.pwdata[7:0];
				REG_HEX:     hex_value <= apb.pwdata[15:0];
				default: ;
			endcase
		end
	end

	// read mux, zero for unmapped addresses
	always_comb begin
		case (apb.paddr)
			REG_KEYCODE: rd_data = {24'h000000, keycode};
			REG_HEX:     rd_data = {16'h0000, hex_value};
			REG_POS:     rd_data = {6'b000000, pos.y, 6'b000000, pos.x};
			REG_STATUS:  rd_data = {30'h00000000, flags.climb, flags.walk};
			default:     rd_data = 32'h00000000;
		endcase
	end

	assign apb_rsp.prdata  = rd_data;
	assign apb_rsp.pready  = 1'b1;
	assign apb_rsp.pslverr = access & ~addr_ok;

	assign ledr = {flags.climb, flags.walk, keycode};

	// master keeps psel up through the access phase
	a_penable_in_sel: assert property (@(posedge clk) disable iff (!rst_n)
		apb.penable |-> apb.psel);

endmodule

`default_nettype wire

// ==== burger_top.sv ====
//==========================================================
// burger top
// chef control core: vga timing, stage map, chef motion,
// apb registers and seven segment displays
//==========================================================
`timescale 1ns/100ps
`default_nettype none

module burger_top #(
	parameter int H_VISIBLE = 640,
	parameter int H_FRONT   = 16,
	parameter int H_SYNC    = 96,
	parameter int H_BACK    = 48,
	parameter int V_VISIBLE = 480,
	parameter int V_FRONT   = 10,
	parameter int V_SYNC    = 2,
	parameter int V_BACK    = 33
) (
	input  wire logic                  max10_clk1_50,
	input  wire logic                  rst_n,
	input  wire burger_pkg::apb_req_t  apb,
	output burger_pkg::apb_rsp_t       apb_rsp,
	output burger_pkg::vga_sync_t      vga,
	output logic [7:0]                 hex0,
	output logic [7:0]                 hex1,
	output logic [7:0]                 hex2,
	output logic [7:0]                 hex3,
	output logic [7:0]                 hex4,
	output logic [7:0]                 hex5,
	output logic [9:0]                 ledr
);

	import burger_pkg::*;

	logic        frame_tick;
	logic [7:0]  keycode;
	logic [15:0] hex_value;
	chef_pos_t   pos;
	map_flags_t  flags;

	vga_sync_gen #(
		.H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) i_vga_sync_gen (
		.clk(max10_clk1_50),
		.rst_n(rst_n),
		.vga(vga),
		.frame_tick(frame_tick)
	);

	// position and flags loop through the map each cycle
	stage_map i_stage_map (
		.pos(pos),
		.flags(flags)
	);

	chef_motion i_chef_motion (
		.clk(max10_clk1_50),
		.rst_n(rst_n),
		.frame_tick(frame_tick),
		.keycode(keycode),
		.flags(flags),
		.pos(pos)
	);

	apb_regs i_apb_regs (
		.clk(max10_clk1_50),
		.rst_n(rst_n),
		.apb(apb),
		.apb_rsp(apb_rsp),
		.pos(pos),
		.flags(flags),
		.keycode(keycode),
		.hex_value(hex_value),
		.ledr(ledr)
	);

	hex_digit_drivers i_hex_digit_drivers (
		.hex_value(hex_value),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.hex4(hex4),
		.hex5(hex5)
	);

endmodule

`default_nettype wire

// ==== tb_burger_top.sv ====
//==========================================================
// burger top testbench
// apb stimulus, chef reference model and frame by frame checks
//==========================================================
`timescale 1ns/100ps
`default_nettype none

module tb_burger_top;

	import burger_pkg::*;

	localparam int FRAME_CLOCKS = 2 * 24 * 12;
	localparam int FRAME_LINES  = 12;
	localparam int VIS_CLOCKS   = 2 * 16 * 8;
	localparam int WAIT_LIMIT   = 2000;
	// active low segments 0 to F, decimal point off
	localparam logic [7:0] SEG_TABLE [16] = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92,
		8'h82, 8'hF8, 8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E};

	logic       clk;
	logic       rst_n;
	apb_req_t   apb;
	apb_rsp_t   apb_rsp;
	vga_sync_t  vga;
	logic [7:0] hex0;
	logic [7:0] hex1;
	logic [7:0] hex2;
	logic [7:0] hex3;
	logic [7:0] hex4;
	logic [7:0] hex5;
	logic [9:0] ledr;
	chef_pos_t  model;
	chef_pos_t  pos_last;
	logic       tick_last;
	int         errors;
	int         tests;
	int         failed_tests;
	int         stray_moves;
	int         tick_moves;
	integer     seed;

	burger_top #(
		.H_VISIBLE(16), .H_FRONT(2), .H_SYNC(4), .H_BACK(2),
		.V_VISIBLE(8), .V_FRONT(1), .V_SYNC(1), .V_BACK(2)
	) i_burger_top (
		.max10_clk1_50(clk),
		.rst_n(rst_n),
		.apb(apb),
		.apb_rsp(apb_rsp),
		.vga(vga),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.hex4(hex4),
		.hex5(hex5),
		.ledr(ledr)
	);

	always #5 clk = ~clk;

	// watch the chef position, moves only right after a frame tick
	always @(negedge clk) begin
		if (rst_n && (i_burger_top.pos != pos_last)) begin
			if (tick_last)
				tick_moves++;
			else
				stray_moves++;
		end
		pos_last  = i_burger_top.pos;
		tick_last = i_burger_top.frame_tick;
	end

	//==========================================================
	// reference model
	//==========================================================
	function automatic map_flags_t map_ref(input chef_pos_t p);
		map_flags_t f;
		int         phase;
		phase   = (int'(p.x) + int'(CHEF_HALF)) % int'(LADDER_PITCH);
		f.walk  = (p.y >= FLOOR_BASE) &&
			(((int'(p.y) - int'(FLOOR_BASE)) % int'(FLOOR_PITCH)) == 0);
		f.climb = (phase >= int'(LADDER_OFFSET)) &&
			(phase < int'(LADDER_OFFSET) + int'(LADDER_WIDTH)) &&
			(p.y >= CHEF_Y_MIN) && (p.y <= CHEF_Y_MAX);
		return f;
	endfunction

	function automatic chef_pos_t step_ref(input chef_pos_t p, input logic [7:0] key);
		map_flags_t f;
		chef_pos_t  n;
		f = map_ref(p);
		n = p;
		if ((key == KEY_LEFT) && f.walk && (p.x > 10'd0))
			n.x = p.x - 10'd1;
		else if ((key == KEY_RIGHT) && f.walk && (p.x < CHEF_X_MAX))
			n.x = p.x + 10'd1;
		else if ((key == KEY_UP) && f.climb && (p.y > CHEF_Y_MIN))
			n.y = p.y - 10'd1;
		else if ((key == KEY_DOWN) && f.climb && (p.y < CHEF_Y_MAX))
			n.y = p.y + 10'd1;
		return n;
	endfunction

	//==========================================================
	// bus and frame helpers
	//==========================================================
	task automatic report_mismatch(input string sig, input logic [31:0] got,
			input logic [31:0] exp);
		$display("FAILED %s got %h expected %h", sig, got, exp);
		errors++;
	endtask

	// called on a falling edge, returns on a falling edge
	task automatic apb_access(input logic wr, input logic [3:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waited;
		waited = 0;
		apb = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(negedge clk);
		apb.penable = 1'b1;
		#1;
		while (apb_rsp.pready !== 1'b1) begin
			@(negedge clk);
			#1;
			waited++;
			if (waited > WAIT_LIMIT) begin
				$display("timeout waiting for pready");
				$display("Some tests failed");
				$finish;
			end
		end
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(negedge clk);
		apb = '0;
	endtask

	task automatic wait_vs_fall(output int clocks);
		logic prev;
		logic fell;
		clocks = 0;
		prev   = vga.vs;
		fell   = 1'b0;
		while (!fell) begin
			@(negedge clk);
			clocks++;
			fell = prev && !vga.vs;
			prev = vga.vs;
			if (clocks > WAIT_LIMIT) begin
				$display("timeout waiting for a vs falling edge");
				$display("Some tests failed");
				$finish;
			end
		end
	endtask

	// one whole frame up to the next vs fall, with hs falls and visible clocks
	task automatic measure_frame(output int clocks, output int hs_falls,
			output int vis_clocks);
		logic vs_prev;
		logic hs_prev;
		logic fell;
		clocks     = 0;
		hs_falls   = 0;
		vis_clocks = 0;
		vs_prev    = vga.vs;
		hs_prev    = vga.hs;
		fell       = 1'b0;
		while (!fell) begin
			@(negedge clk);
			clocks++;
			if (hs_prev && !vga.hs)
				hs_falls++;
			if (vga.blank)
				vis_clocks++;
			fell    = vs_prev && !vga.vs;
			vs_prev = vga.vs;
			hs_prev = vga.hs;
			if (clocks > WAIT_LIMIT) begin
				$display("timeout waiting for the end of a frame");
				$display("Some tests failed");
				$finish;
			end
		end
	endtask

	// pos has taken the tick two clocks after vs falls
	task automatic wait_frame();
		int n;
		wait_vs_fall(n);
		@(negedge clk);
		@(negedge clk);
	endtask

	task automatic compare_pos(input chef_pos_t exp);
		logic [31:0] rd;
		logic        err;
		map_flags_t  f;
		f = map_ref(exp);
		apb_access(1'b0, REG_POS, 32'd0, rd, err);
		if (rd != {6'd0, exp.y, 6'd0, exp.x})
			report_mismatch("REG_POS", rd, {6'd0, exp.y, 6'd0, exp.x});
		if ((rd[25:16] < CHEF_Y_MIN) || (rd[25:16] > CHEF_Y_MAX)) begin
			$display("chef y %0d left the stage range", rd[25:16]);
			errors++;
		end
		apb_access(1'b0, REG_STATUS, 32'd0, rd, err);
		if (rd != {30'd0, f.climb, f.walk})
			report_mismatch("REG_STATUS", rd, {30'd0, f.climb, f.walk});
	endtask

	task automatic run_frames(input logic [7:0] key, input int count);
		logic [31:0] rd;
		logic        err;
		apb_access(1'b1, REG_KEYCODE, {24'd0, key}, rd, err);
		repeat (count) begin
			wait_frame();
			model = step_ref(model, key);
			compare_pos(model);
		end
	endtask

	task automatic check_digits(input logic [15:0] hv);
		if (hex0 != SEG_TABLE[hv[3:0]])
			report_mismatch("hex0", 32'(hex0), 32'(SEG_TABLE[hv[3:0]]));
		if (hex1 != SEG_TABLE[hv[7:4]])
			report_mismatch("hex1", 32'(hex1), 32'(SEG_TABLE[hv[7:4]]));
		if (hex3 != SEG_TABLE[hv[11:8]])
			report_mismatch("hex3", 32'(hex3), 32'(SEG_TABLE[hv[11:8]]));
		if (hex4 != SEG_TABLE[hv[15:12]])
			report_mismatch("hex4", 32'(hex4), 32'(SEG_TABLE[hv[15:12]]));
		if (hex2 != 8'hFF)
			report_mismatch("hex2", 32'(hex2), 32'hFF);
		if (hex5 != 8'hFF)
			report_mismatch("hex5", 32'(hex5), 32'hFF);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before) begin
			$display("test %s done, no errors", name);
		end else begin
			failed_tests++;
			$display("test %s done, %0d errors", name, errors - errs_before);
		end
	endtask

	//==========================================================
	// test sequence
	//==========================================================
	initial begin
		int          n;
		int          hs_falls;
		int          vis_clocks;
		int          start_errs;
		int          moves_before;
		logic [31:0] rd;
		logic [31:0] rnd;
		logic        err;
		logic [15:0] hv;
		logic [7:0]  key;
		map_flags_t  f;
		clk          = 1'b0;
		rst_n        = 1'b0;
		apb          = '0;
		errors       = 0;
		tests        = 0;
		failed_tests = 0;
		stray_moves  = 0;
		tick_moves   = 0;
		pos_last     = '0;
		tick_last    = 1'b0;
		hv           = 16'h0000;
		seed         = 32'h2d4ea78d;
		model        = '{x: CHEF_X_START, y: CHEF_Y_START};
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		start_errs = errors;
		compare_pos(model);
		apb_access(1'b0, REG_KEYCODE, 32'd0, rd, err);
		if (rd != 32'd0)
			report_mismatch("REG_KEYCODE", rd, 32'd0);
		check_digits(16'h0000);
		if (vga.vs !== 1'b1)
			report_mismatch("vga.vs", 32'(vga.vs), 32'd1);
		finish_test("1 reset state", start_errs);

		// keycodes with bit 7 set never move the chef
		start_errs = errors;
		repeat (8) begin
			hv  = 16'($random(seed));
			key = 8'($random(seed)) | 8'h80;
			apb_access(1'b1, REG_HEX, {16'd0, hv}, rd, err);
			apb_access(1'b1, REG_KEYCODE, {24'd0, key}, rd, err);
			apb_access(1'b0, REG_HEX, 32'd0, rd, err);
			if (rd != {16'd0, hv})
				report_mismatch("REG_HEX", rd, {16'd0, hv});
			check_digits(hv);
			f = map_ref(model);
			if (ledr != {f.climb, f.walk, key})
				report_mismatch("ledr", 32'(ledr), 32'({f.climb, f.walk, key}));
		end
		apb_access(1'b1, REG_KEYCODE, 32'd0, rd, err);
		finish_test("2 hex and led", start_errs);

		start_errs = errors;
		wait_frame();
		compare_pos(model);
		run_frames(KEY_UP, 20);
		apb_access(1'b0, REG_STATUS, 32'd0, rd, err);
		if (rd[0] != 1'b0)
			report_mismatch("REG_STATUS walk", 32'(rd[0]), 32'd0);
		run_frames(KEY_RIGHT, 3);
		run_frames(KEY_DOWN, 20);
		run_frames(KEY_RIGHT, 3);
		apb_access(1'b0, REG_POS, 32'd0, rd, err);
		if (rd[9:0] != 10'd27)
			report_mismatch("REG_POS x", 32'(rd[9:0]), 32'd27);
		finish_test("3 climb and walk", start_errs);

		start_errs = errors;
		repeat (60) begin
			rnd = $random(seed);
			case (rnd[2:0])
				3'd0: key = KEY_LEFT;
				3'd1: key = KEY_RIGHT;
				3'd2: key = KEY_UP;
				3'd3: key = KEY_DOWN;
				default: key = rnd[15:8];
			endcase
			run_frames(key, 1);
		end
		apb_access(1'b1, REG_KEYCODE, 32'd0, rd, err);
		finish_test("4 random keys", start_errs);

		start_errs = errors;
		apb_access(1'b0, 4'd2, 32'd0, rd, err);
		if (err !== 1'b1)
			report_mismatch("pslverr", 32'(err), 32'd1);
		if (rd != 32'd0)
			report_mismatch("prdata", rd, 32'd0);
		apb_access(1'b1, 4'd13, 32'hFFFF_FFFF, rd, err);
		if (err !== 1'b1)
			report_mismatch("pslverr", 32'(err), 32'd1);
		apb_access(1'b0, REG_KEYCODE, 32'd0, rd, err);
		if (rd != 32'd0)
			report_mismatch("REG_KEYCODE", rd, 32'd0);
		apb_access(1'b0, REG_HEX, 32'd0, rd, err);
		if (rd != {16'd0, hv})
			report_mismatch("REG_HEX", rd, {16'd0, hv});
		apb_access(1'b1, REG_POS, 32'h0155_0155, rd, err);
		if (err !== 1'b0)
			report_mismatch("pslverr", 32'(err), 32'd0);
		compare_pos(model);
		finish_test("5 apb errors", start_errs);

		// a key that moves, so the move monitor has work
		start_errs   = errors;
		f            = map_ref(model);
		key          = f.walk ? KEY_RIGHT : KEY_UP;
		moves_before = tick_moves;
		apb_access(1'b1, REG_KEYCODE, {24'd0, key}, rd, err);
		wait_vs_fall(n);
		measure_frame(n, hs_falls, vis_clocks);
		if (n != FRAME_CLOCKS)
			report_mismatch("vs period", 32'(n), 32'(FRAME_CLOCKS));
		if (hs_falls != FRAME_LINES)
			report_mismatch("vga.hs falls", 32'(hs_falls), 32'(FRAME_LINES));
		if (vis_clocks != VIS_CLOCKS)
			report_mismatch("vga.blank high clocks", 32'(vis_clocks), 32'(VIS_CLOCKS));
		if (tick_moves == moves_before) begin
			$display("chef did not move on any frame tick");
			errors++;
		end
		if (stray_moves != 0) begin
			$display("chef position changed %0d times between frame ticks", stray_moves);
			errors++;
		end
		finish_test("6 frame timing", start_errs);

		$display("%0d tests, %0d failed, %0d check errors", tests, failed_tests, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
burger_pkg.sv
vga_sync_gen.sv
stage_map.sv
chef_motion.sv
hex_digit_drivers.sv
apb_regs.sv
burger_top.sv
tb_burger_top.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_burger_top
FILELIST = sim.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
